/* design/rab_cfg_pkg.sv */
package rab_cfg_pkg;

  // --------------------
  // Bus widths
  // --------------------

  // Cluster and system bus address width
  localparam int unsigned ADDR_W = 32;

  // Transaction ID width on the cluster request channel
  localparam int unsigned ID_W = 4;

  // Data width of the configuration port
  localparam int unsigned DATA_W = 32;

  // --------------------
  // Vector types
  // --------------------

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [DATA_W-1:0] data_t;

endpackage

/* design/rab_conf_decode.sv */
`timescale 1ns/1ps

module rab_conf_decode #(
  parameter int unsigned N_SLICES = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  rab_cfg_pkg::addr_t  conf_aw_addr_i,
  input  logic                conf_aw_valid_i,
  output logic                conf_aw_ready_o,
  input  rab_cfg_pkg::data_t  conf_w_data_i,
  input  logic                conf_w_valid_i,
  output logic                conf_w_ready_o,
  output rab_regs_pkg::resp_t conf_b_resp_o,
  output logic                conf_b_valid_o,
  input  logic                conf_b_ready_i,
  input  rab_cfg_pkg::addr_t  conf_ar_addr_i,
  input  logic                conf_ar_valid_i,
  output logic                conf_ar_ready_o,
  output rab_cfg_pkg::data_t  conf_r_data_o,
  output rab_regs_pkg::resp_t conf_r_resp_o,
  output logic                conf_r_valid_o,
  input  logic                conf_r_ready_i,
  rab_slice_if.owner          slice,
  rab_miss_if.reader          miss
);

  import rab_cfg_pkg::*;
  import rab_regs_pkg::*;

  localparam int unsigned IDX_W     = (N_SLICES > 1) ? $clog2(N_SLICES) : 1;
  localparam int unsigned TAB_BYTES = N_SLICES * SLICE_STRIDE;

  typedef logic [IDX_W-1:0] idx_t;

  logic        wr_acc;
  logic        wr_tab;
  idx_t        wr_idx;
  int unsigned wr_fld;
  resp_t       wr_resp;
  logic        rd_acc;
  logic        rd_tab;
  idx_t        rd_idx;
  int unsigned rd_fld;
  resp_t       rd_resp;
  data_t       rd_data;
  logic        b_valid_q;
  resp_t       b_resp_q;
  logic        r_valid_q;
  resp_t       r_resp_q;
  data_t       r_data_q;

  // Word inside the slice table that names one of the four slice fields
  function automatic logic in_table(addr_t a);
    int unsigned fld;
    fld = a % SLICE_STRIDE;
    return (a < TAB_BYTES) && (fld inside {OFS_START, OFS_END, OFS_OFFSET, OFS_FLAGS});
  endfunction

  // --------------------
  // Write path
  // --------------------

  assign wr_tab = in_table(conf_aw_addr_i);
  assign wr_idx = idx_t'(conf_aw_addr_i / SLICE_STRIDE);
  assign wr_fld = conf_aw_addr_i % SLICE_STRIDE;

  // Address and data are taken together, and only once the last B is gone
  assign wr_acc          = conf_aw_valid_i && conf_w_valid_i && !b_valid_q;
  assign conf_aw_ready_o = wr_acc;
  assign conf_w_ready_o  = wr_acc;

  always_comb begin
    if (wr_tab) begin
      wr_resp = RESP_OKAY;
    end else if (conf_aw_addr_i == MISS_ID_ADDR || conf_aw_addr_i == MISS_POP_ADDR) begin
      // The miss registers are read only
      wr_resp = RESP_SLVERR;
    end else begin
      wr_resp = RESP_DECERR;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_acc && wr_tab) begin
      case (wr_fld)
        OFS_START:  slice.slice_start[wr_idx]  <= addr_t'(conf_w_data_i);
        OFS_END:    slice.slice_end[wr_idx]    <= addr_t'(conf_w_data_i);
        OFS_OFFSET: slice.slice_offset[wr_idx] <= addr_t'(conf_w_data_i);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slice.slice_en <= '0;
      slice.slice_rd <= '0;
      slice.slice_wr <= '0;
    end else if (wr_acc && wr_tab && (wr_fld == OFS_FLAGS)) begin
      slice.slice_en[wr_idx] <= conf_w_data_i[FLAG_EN];
      slice.slice_rd[wr_idx] <= conf_w_data_i[FLAG_RD];
      slice.slice_wr[wr_idx] <= conf_w_data_i[FLAG_WR];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_acc) begin
      b_valid_q <= 1'b1;
    end else if (conf_b_ready_i) begin
      b_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      b_resp_q <= wr_resp;
    end
  end

  // --------------------
  // Read path
  // --------------------

  assign rd_tab          = in_table(conf_ar_addr_i);
  assign rd_idx          = idx_t'(conf_ar_addr_i / SLICE_STRIDE);
  assign rd_fld          = conf_ar_addr_i % SLICE_STRIDE;
  assign conf_ar_ready_o = !r_valid_q;
  assign rd_acc          = conf_ar_valid_i && !r_valid_q;

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_DECERR;
    if (rd_tab) begin
      rd_resp = RESP_OKAY;
      case (rd_fld)
        OFS_START:  rd_data = data_t'(slice.slice_start[rd_idx]);
        OFS_END:    rd_data = data_t'(slice.slice_end[rd_idx]);
        OFS_OFFSET: rd_data = data_t'(slice.slice_offset[rd_idx]);
        OFS_FLAGS: begin
          rd_data[FLAG_EN] = slice.slice_en[rd_idx];
          rd_data[FLAG_RD] = slice.slice_rd[rd_idx];
          rd_data[FLAG_WR] = slice.slice_wr[rd_idx];
        end
        default: ;
      endcase
    end else if (conf_ar_addr_i == MISS_ID_ADDR || conf_ar_addr_i == MISS_POP_ADDR) begin
      if (miss.empty) begin
        rd_resp = RESP_SLVERR;
      end else begin
        rd_resp = RESP_OKAY;
        rd_data = (conf_ar_addr_i == MISS_ID_ADDR) ? data_t'(miss.head_id)
                                                   : data_t'(miss.head_addr);
      end
    end
  end

  // Pop in the cycle the head address is captured into R
  assign miss.pop = rd_acc && (conf_ar_addr_i == MISS_POP_ADDR) && !miss.empty;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_acc) begin
      r_valid_q <= 1'b1;
    end else if (conf_r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  assign conf_b_valid_o = b_valid_q;
  assign conf_b_resp_o  = b_resp_q;
  assign conf_r_valid_o = r_valid_q;
  assign conf_r_data_o  = r_data_q;
  assign conf_r_resp_o  = r_resp_q;

endmodule

/* design/rab_if.sv */
`timescale 1ns/1ps

// Slice table as held by the configuration decoder
interface rab_slice_if #(
  parameter int unsigned N_SLICES = 4
);

  import rab_cfg_pkg::*;

  addr_t               slice_start  [N_SLICES];
  addr_t               slice_end    [N_SLICES];
  addr_t               slice_offset [N_SLICES];
  logic [N_SLICES-1:0] slice_en;
  logic [N_SLICES-1:0] slice_rd;
  logic [N_SLICES-1:0] slice_wr;

  modport owner  (output slice_start, slice_end, slice_offset, slice_en, slice_rd, slice_wr);
  modport reader (input  slice_start, slice_end, slice_offset, slice_en, slice_rd, slice_wr);

endinterface

// Lookup result handed from the lookup stage to the response stage
interface rab_xlat_if;

  import rab_cfg_pkg::*;

  logic  valid;
  logic  ready;
  addr_t xaddr;
  addr_t addr;
  id_t   id;
  logic  write;
  logic  hit;
  logic  multi;
  logic  prot_err;

  modport source (output valid, xaddr, addr, id, write, hit, multi, prot_err, input ready);
  modport sink   (input  valid, xaddr, addr, id, write, hit, multi, prot_err, output ready);

endinterface

// Head of the miss FIFO, seen by the configuration decoder
interface rab_miss_if;

  import rab_cfg_pkg::*;

  logic  empty;
  addr_t head_addr;
  id_t   head_id;
  logic  pop;

  modport owner  (output empty, head_addr, head_id, input pop);
  modport reader (input  empty, head_addr, head_id, output pop);

endinterface

/* design/rab_lookup.sv */
`timescale 1ns/1ps

module rab_lookup #(
  parameter int unsigned N_SLICES = 4
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  rab_cfg_pkg::addr_t req_addr_i,
  input  rab_cfg_pkg::id_t   req_id_i,
  input  logic               req_write_i,
  rab_slice_if.reader        slice,
  rab_xlat_if.source         xlat
);

  import rab_cfg_pkg::*;

  localparam int unsigned IDX_W = (N_SLICES > 1) ? $clog2(N_SLICES) : 1;

  logic [N_SLICES-1:0] hit_vec;
  logic [IDX_W-1:0]    sel;
  logic                any_hit;
  logic                multi_hit;
  logic                perm_ok;
  logic                prot_err;
  addr_t               xaddr;

  // All slices are compared against the request at once
  always_comb begin
    for (int i = 0; i < N_SLICES; i++) begin
      hit_vec[i] = slice.slice_en[i] &&
                   (req_addr_i >= slice.slice_start[i]) &&
                   (req_addr_i <= slice.slice_end[i]);
    end
  end

  // Scanning downward leaves the lowest hitting slice in sel
  always_comb begin
    sel = '0;
    for (int i = N_SLICES - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        sel = IDX_W'(i);
      end
    end
  end

  assign any_hit = |hit_vec;

  // Clearing the lowest set bit leaves something only when two or more slices hit
  assign multi_hit = |(hit_vec & (hit_vec - 1'b1));

  assign perm_ok  = req_write_i ? slice.slice_wr[sel] : slice.slice_rd[sel];
  assign prot_err = any_hit && !multi_hit && !perm_ok;
  assign xaddr    = req_addr_i - slice.slice_start[sel] + slice.slice_offset[sel];

  // --------------------
  // Result register
  // --------------------

  assign req_ready_o = !xlat.valid || xlat.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      xlat.valid <= 1'b0;
    end else if (req_ready_o) begin
      xlat.valid <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      xlat.xaddr    <= xaddr;
      xlat.addr     <= req_addr_i;
      xlat.id       <= req_id_i;
      xlat.write    <= req_write_i;
      xlat.hit      <= any_hit;
      xlat.multi    <= multi_hit;
      xlat.prot_err <= prot_err;
    end
  end

endmodule

/* design/rab_ooc.sv */
`timescale 1ns/1ps

module rab_ooc #(
  parameter int unsigned N_SLICES        = 4,
  parameter int unsigned MISS_FIFO_DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,

  // Configuration port
  input  rab_cfg_pkg::addr_t  conf_aw_addr_i,
  input  logic                conf_aw_valid_i,
  output logic                conf_aw_ready_o,
  input  rab_cfg_pkg::data_t  conf_w_data_i,
  input  logic                conf_w_valid_i,
  output logic                conf_w_ready_o,
  output rab_regs_pkg::resp_t conf_b_resp_o,
  output logic                conf_b_valid_o,
  input  logic                conf_b_ready_i,
  input  rab_cfg_pkg::addr_t  conf_ar_addr_i,
  input  logic                conf_ar_valid_i,
  output logic                conf_ar_ready_o,
  output rab_cfg_pkg::data_t  conf_r_data_o,
  output rab_regs_pkg::resp_t conf_r_resp_o,
  output logic                conf_r_valid_o,
  input  logic                conf_r_ready_i,

  // Cluster side
  input  logic                slv_req_valid_i,
  output logic                slv_req_ready_o,
  input  rab_cfg_pkg::addr_t  slv_req_addr_i,
  input  rab_cfg_pkg::id_t    slv_req_id_i,
  input  logic                slv_req_write_i,
  output logic                slv_err_valid_o,
  input  logic                slv_err_ready_i,
  output rab_cfg_pkg::id_t    slv_err_id_o,
  output rab_regs_pkg::resp_t slv_err_resp_o,

  // System bus side
  output logic                mst_req_valid_o,
  input  logic                mst_req_ready_i,
  output rab_cfg_pkg::addr_t  mst_req_addr_o,
  output rab_cfg_pkg::id_t    mst_req_id_o,
  output logic                mst_req_write_o,

  output logic                rab_miss_irq_o,
  output logic                rab_multi_irq_o,
  output logic                rab_prot_irq_o,
  output logic                rab_fifo_full_irq_o
);

  rab_slice_if #(.N_SLICES(N_SLICES)) slice_if ();
  rab_xlat_if                         xlat_if ();
  rab_miss_if                         miss_if ();

  rab_conf_decode #(
    .N_SLICES (N_SLICES)
  ) i_conf_decode (
    .clk_i,
    .reset_i,
    .conf_aw_addr_i,
    .conf_aw_valid_i,
    .conf_aw_ready_o,
    .conf_w_data_i,
    .conf_w_valid_i,
    .conf_w_ready_o,
    .conf_b_resp_o,
    .conf_b_valid_o,
    .conf_b_ready_i,
    .conf_ar_addr_i,
    .conf_ar_valid_i,
    .conf_ar_ready_o,
    .conf_r_data_o,
    .conf_r_resp_o,
    .conf_r_valid_o,
    .conf_r_ready_i,
    .slice (slice_if),
    .miss  (miss_if)
  );

  rab_lookup #(
    .N_SLICES (N_SLICES)
  ) i_lookup (
    .clk_i,
    .reset_i,
    .req_valid_i (slv_req_valid_i),
    .req_ready_o (slv_req_ready_o),
    .req_addr_i  (slv_req_addr_i),
    .req_id_i    (slv_req_id_i),
    .req_write_i (slv_req_write_i),
    .slice       (slice_if),
    .xlat        (xlat_if)
  );

  rab_response #(
    .MISS_FIFO_DEPTH (MISS_FIFO_DEPTH)
  ) i_response (
    .clk_i,
    .reset_i,
    .xlat            (xlat_if),
    .miss            (miss_if),
    .mst_valid_o     (mst_req_valid_o),
    .mst_ready_i     (mst_req_ready_i),
    .mst_addr_o      (mst_req_addr_o),
    .mst_id_o        (mst_req_id_o),
    .mst_write_o     (mst_req_write_o),
    .err_valid_o     (slv_err_valid_o),
    .err_ready_i     (slv_err_ready_i),
    .err_id_o        (slv_err_id_o),
    .err_resp_o      (slv_err_resp_o),
    .miss_irq_o      (rab_miss_irq_o),
    .multi_irq_o     (rab_multi_irq_o),
    .prot_irq_o      (rab_prot_irq_o),
    .fifo_full_irq_o (rab_fifo_full_irq_o)
  );

endmodule

/* design/rab_regs_pkg.sv */
package rab_regs_pkg;

  // Response codes on the configuration and error channels
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;
  localparam resp_t RESP_DECERR = 2'd3;

  // --------------------
  // Slice registers
  // --------------------

  // Each slice occupies one block of four words starting at address 0
  localparam int unsigned SLICE_STRIDE = 16;

  localparam int unsigned OFS_START  = 0;
  localparam int unsigned OFS_END    = 4;
  localparam int unsigned OFS_OFFSET = 8;
  localparam int unsigned OFS_FLAGS  = 12;

  // Bit positions in the flags word
  localparam int unsigned FLAG_EN = 0;
  localparam int unsigned FLAG_RD = 1;
  localparam int unsigned FLAG_WR = 2;

  // The miss FIFO head is read through one register without pop and one with pop
  localparam rab_cfg_pkg::addr_t MISS_ID_ADDR  = rab_cfg_pkg::addr_t'('h100);
  localparam rab_cfg_pkg::addr_t MISS_POP_ADDR = rab_cfg_pkg::addr_t'('h104);

endpackage

/* design/rab_response.sv */
`timescale 1ns/1ps

module rab_response #(
  parameter int unsigned MISS_FIFO_DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  rab_xlat_if.sink            xlat,
  rab_miss_if.owner           miss,
  output logic                mst_valid_o,
  input  logic                mst_ready_i,
  output rab_cfg_pkg::addr_t  mst_addr_o,
  output rab_cfg_pkg::id_t    mst_id_o,
  output logic                mst_write_o,
  output logic                err_valid_o,
  input  logic                err_ready_i,
  output rab_cfg_pkg::id_t    err_id_o,
  output rab_regs_pkg::resp_t err_resp_o,
  output logic                miss_irq_o,
  output logic                multi_irq_o,
  output logic                prot_irq_o,
  output logic                fifo_full_irq_o
);

  import rab_cfg_pkg::*;
  import rab_regs_pkg::*;

  localparam int unsigned PTR_W = (MISS_FIFO_DEPTH > 1) ? $clog2(MISS_FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(MISS_FIFO_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;

  logic             take;
  logic             to_mst;
  logic             is_miss;
  logic             push;
  logic             pop;
  logic             full;
  addr_t            fifo_addr [MISS_FIFO_DEPTH];
  id_t              fifo_id   [MISS_FIFO_DEPTH];
  ptr_t             wr_ptr;
  ptr_t             rd_ptr;
  logic [CNT_W-1:0] count;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(MISS_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Both output registers have to be free or draining, so results never overtake
  // each other across the master and error ports
  assign xlat.ready = (!mst_valid_o || mst_ready_i) && (!err_valid_o || err_ready_i);
  assign take       = xlat.valid && xlat.ready;
  assign to_mst     = xlat.hit && !xlat.multi && !xlat.prot_err;
  assign is_miss    = !xlat.hit;

  // --------------------
  // Output registers
  // --------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mst_valid_o <= 1'b0;
      err_valid_o <= 1'b0;
    end else if (take) begin
      mst_valid_o <= to_mst;
      err_valid_o <= !to_mst;
    end else begin
      if (mst_ready_i) mst_valid_o <= 1'b0;
      if (err_ready_i) err_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take && to_mst) begin
      mst_addr_o  <= xlat.xaddr;
      mst_id_o    <= xlat.id;
      mst_write_o <= xlat.write;
    end
    if (take && !to_mst) begin
      err_id_o <= xlat.id;
    end
  end

  // Miss, multi-hit and protection errors all report a slave error
  assign err_resp_o = RESP_SLVERR;

  // Pulses line up with the error entering its output register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_irq_o  <= 1'b0;
      multi_irq_o <= 1'b0;
      prot_irq_o  <= 1'b0;
    end else begin
      miss_irq_o  <= take && is_miss;
      multi_irq_o <= take && xlat.multi;
      prot_irq_o  <= take && xlat.prot_err;
    end
  end

  // --------------------
  // Miss FIFO
  // --------------------

  assign full = (count == CNT_W'(MISS_FIFO_DEPTH));
  assign push = take && is_miss && !full;
  assign pop  = miss.pop && (count != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_addr[wr_ptr] <= xlat.addr;
      fifo_id[wr_ptr]   <= xlat.id;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  assign miss.empty      = (count == '0);
  assign miss.head_addr  = fifo_addr[rd_ptr];
  assign miss.head_id    = fifo_id[rd_ptr];
  assign fifo_full_irq_o = full;

endmodule

/* rab_lite.f */
design/rab_cfg_pkg.sv
design/rab_regs_pkg.sv
design/rab_if.sv
design/rab_conf_decode.sv
design/rab_lookup.sv
design/rab_response.sv
design/rab_ooc.sv
testbench/rab_tb.sv

/* testbench/rab_tb.sv */
`timescale 1ns/1ps

module rab_tb;

  import rab_cfg_pkg::*;
  import rab_regs_pkg::*;

  localparam int N_SLICES   = 4;
  localparam int MISS_DEPTH = 4;
  localparam int N_XLAT     = 40;
  localparam int N_BP       = 60;
  localparam int N_LAT      = 8;

  // Worst case is roughly 16 cycles per request and 8 per configuration access
  localparam int N_REQ_MAX  = N_XLAT + N_BP + N_LAT + 2 * MISS_DEPTH + 16;
  localparam int N_CONF_MAX = 8 * N_SLICES + 64;
  localparam int MAX_CYCLES = 10 + 16 * N_REQ_MAX + 8 * N_CONF_MAX;

  localparam logic [1:0] KIND_OK    = 2'd0;
  localparam logic [1:0] KIND_MISS  = 2'd1;
  localparam logic [1:0] KIND_MULTI = 2'd2;
  localparam logic [1:0] KIND_PROT  = 2'd3;

  typedef struct packed {
    logic [1:0]  kind;
    addr_t       addr;
    id_t         id;
    logic        write;
    logic        lat_chk;
    logic [31:0] cyc;
  } exp_t;

  logic  clk_i;
  logic  reset_i;
  addr_t conf_aw_addr_i;
  logic  conf_aw_valid_i;
  logic  conf_aw_ready_o;
  data_t conf_w_data_i;
  logic  conf_w_valid_i;
  logic  conf_w_ready_o;
  resp_t conf_b_resp_o;
  logic  conf_b_valid_o;
  logic  conf_b_ready_i;
  addr_t conf_ar_addr_i;
  logic  conf_ar_valid_i;
  logic  conf_ar_ready_o;
  data_t conf_r_data_o;
  resp_t conf_r_resp_o;
  logic  conf_r_valid_o;
  logic  conf_r_ready_i;
  logic  slv_req_valid_i;
  logic  slv_req_ready_o;
  addr_t slv_req_addr_i;
  id_t   slv_req_id_i;
  logic  slv_req_write_i;
  logic  slv_err_valid_o;
  logic  slv_err_ready_i;
  id_t   slv_err_id_o;
  resp_t slv_err_resp_o;
  logic  mst_req_valid_o;
  logic  mst_req_ready_i;
  addr_t mst_req_addr_o;
  id_t   mst_req_id_o;
  logic  mst_req_write_o;
  logic  rab_miss_irq_o;
  logic  rab_multi_irq_o;
  logic  rab_prot_irq_o;
  logic  rab_fifo_full_irq_o;

  // Shadow of the slice table and of the miss FIFO
  addr_t       sh_start [N_SLICES];
  addr_t       sh_end   [N_SLICES];
  addr_t       sh_off   [N_SLICES];
  data_t       sh_flags [N_SLICES];
  addr_t       miss_addr_q [$];
  id_t         miss_id_q   [$];
  exp_t        exp_q       [$];
  int          exp_cnt [4];
  int          irq_cnt [4];
  int          n_checks;
  int          n_errors;
  logic [31:0] cycle;
  logic [31:0] stim_lfsr;
  logic [31:0] rdy_lfsr;
  logic        rand_ready;
  string       cur_test;
  exp_t        got_e;
  logic        mst_hold;
  logic        err_hold;
  addr_t       hold_addr;
  id_t         hold_mst_id;
  logic        hold_write;
  id_t         hold_err_id;

  rab_ooc #(
    .N_SLICES        (N_SLICES),
    .MISS_FIFO_DEPTH (MISS_DEPTH)
  ) uut (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      r = {r[30:0], stim_lfsr[0]};
    end
    return r;
  endfunction

  // Expected outcome of one request against the shadow table
  function automatic exp_t ref_xlat(input addr_t a, input logic wr);
    exp_t e;
    int   hits;
    int   first;
    logic perm;
    e     = '0;
    hits  = 0;
    first = -1;
    for (int i = 0; i < N_SLICES; i++) begin
      if (sh_flags[i][FLAG_EN] && a >= sh_start[i] && a <= sh_end[i]) begin
        hits++;
        if (first < 0) first = i;
      end
    end
    if (hits == 0) begin
      e.kind = KIND_MISS;
    end else if (hits > 1) begin
      e.kind = KIND_MULTI;
    end else begin
      perm = wr ? sh_flags[first][FLAG_WR] : sh_flags[first][FLAG_RD];
      e.kind = perm ? KIND_OK : KIND_PROT;
      if (perm) e.addr = a - sh_start[first] + sh_off[first];
    end
    return e;
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Mismatch %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    end
  endtask

  // --------------------
  // Configuration port
  // --------------------

  task automatic cfg_write(input addr_t a, input data_t d, input resp_t exp, input string what);
    int idx;
    @(negedge clk_i);
    conf_aw_addr_i  = a;
    conf_aw_valid_i = 1'b1;
    conf_w_data_i   = d;
    conf_w_valid_i  = 1'b1;
    @(posedge clk_i);
    while (!conf_aw_ready_o) @(posedge clk_i);
    check({what, " w ready"}, 1'b1, conf_w_ready_o);
    @(negedge clk_i);
    conf_aw_valid_i = 1'b0;
    conf_w_valid_i  = 1'b0;
    @(posedge clk_i);
    while (!conf_b_valid_o) @(posedge clk_i);
    check(what, exp, conf_b_resp_o);
    if (exp == RESP_OKAY && a < N_SLICES * SLICE_STRIDE) begin
      idx = a / SLICE_STRIDE;
      case (a % SLICE_STRIDE)
        OFS_START:  sh_start[idx] = d;
        OFS_END:    sh_end[idx]   = d;
        OFS_OFFSET: sh_off[idx]   = d;
        default:    sh_flags[idx] = d;
      endcase
    end
  endtask

  task automatic cfg_read(input addr_t a, input data_t exp_d, input resp_t exp_r,
                          input string what);
    @(negedge clk_i);
    conf_ar_addr_i  = a;
    conf_ar_valid_i = 1'b1;
    @(posedge clk_i);
    while (!conf_ar_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    conf_ar_valid_i = 1'b0;
    @(posedge clk_i);
    while (!conf_r_valid_o) @(posedge clk_i);
    check({what, " data"}, exp_d, conf_r_data_o);
    check({what, " resp"}, exp_r, conf_r_resp_o);
  endtask

  task automatic set_slice(input int i, input addr_t s, input addr_t e, input addr_t o,
                           input data_t f);
    cfg_write(i * SLICE_STRIDE + OFS_START, s, RESP_OKAY, "start write");
    cfg_write(i * SLICE_STRIDE + OFS_END, e, RESP_OKAY, "end write");
    cfg_write(i * SLICE_STRIDE + OFS_OFFSET, o, RESP_OKAY, "offset write");
    cfg_write(i * SLICE_STRIDE + OFS_FLAGS, f, RESP_OKAY, "flags write");
  endtask

  // Pops every logged miss, then checks the empty response
  task automatic check_miss_log();
    while (miss_addr_q.size() != 0) begin
      cfg_read(MISS_ID_ADDR, data_t'(miss_id_q.pop_front()), RESP_OKAY, "miss id");
      cfg_read(MISS_POP_ADDR, data_t'(miss_addr_q.pop_front()), RESP_OKAY, "miss addr");
    end
    cfg_read(MISS_ID_ADDR, '0, RESP_SLVERR, "empty miss id");
    cfg_read(MISS_POP_ADDR, '0, RESP_SLVERR, "empty miss pop");
  endtask

  // --------------------
  // Cluster requests
  // --------------------

  task automatic send_req(input addr_t a, input id_t id, input logic wr);
    exp_t e;
    e = ref_xlat(a, wr);
    e.id    = id;
    e.write = wr;
    @(negedge clk_i);
    slv_req_valid_i = 1'b1;
    slv_req_addr_i  = a;
    slv_req_id_i    = id;
    slv_req_write_i = wr;
    @(posedge clk_i);
    while (!slv_req_ready_o) @(posedge clk_i);
    e.cyc     = cycle;
    e.lat_chk = !rand_ready;
    exp_q.push_back(e);
    exp_cnt[e.kind]++;
    if (e.kind == KIND_MISS && miss_addr_q.size() < MISS_DEPTH) begin
      miss_addr_q.push_back(a);
      miss_id_q.push_back(id);
    end
  endtask

  task automatic send_rand(input addr_t base, input int span_bits);
    addr_t a;
    id_t   id;
    logic  wr;
    a  = base + rand_bits(span_bits);
    id = id_t'(rand_bits(4));
    wr = rand_bits(1);
    send_req(a, id, wr);
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    slv_req_valid_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic check_irqs();
    check("miss pulses", exp_cnt[KIND_MISS], irq_cnt[KIND_MISS]);
    check("multi pulses", exp_cnt[KIND_MULTI], irq_cnt[KIND_MULTI]);
    check("prot pulses", exp_cnt[KIND_PROT], irq_cnt[KIND_PROT]);
    check("fifo full level", miss_addr_q.size() == MISS_DEPTH, rab_fifo_full_irq_o);
  endtask

  task automatic set_ready_mode(input logic m);
    @(posedge clk_i);
    rand_ready = m;
  endtask

  function automatic addr_t mixed_base(input logic [2:0] sel);
    case (sel)
      3'd0:    return 32'h1000_0000;
      3'd1:    return 32'h2000_0000;
      3'd2:    return 32'h3000_0000;
      3'd3:    return 32'h1000_8000;
      3'd4:    return 32'h1001_0000;
      3'd5:    return 32'h5000_0000;
      3'd6:    return 32'h2000_3f00;
      default: return 32'h0000_0000;
    endcase
  endfunction

  // Ready patterns for the master and error outputs
  always @(negedge clk_i) begin
    if (rand_ready) begin
      rdy_lfsr = lfsr_next(rdy_lfsr);
      mst_req_ready_i = rdy_lfsr[0];
      rdy_lfsr = lfsr_next(rdy_lfsr);
      slv_err_ready_i = rdy_lfsr[0];
    end else begin
      mst_req_ready_i = 1'b1;
      slv_err_ready_i = 1'b1;
    end
  end

  // --------------------
  // Compare process
  // --------------------

  always @(posedge clk_i) begin
    if (reset_i) begin
      mst_hold = 1'b0;
      err_hold = 1'b0;
    end else begin
      if (mst_hold && (!mst_req_valid_o || mst_req_addr_o !== hold_addr ||
                       mst_req_id_o !== hold_mst_id || mst_req_write_o !== hold_write)) begin
        n_errors++;
        $display("Master request dropped or changed before it was accepted in %s", cur_test);
      end
      if (err_hold && (!slv_err_valid_o || slv_err_id_o !== hold_err_id)) begin
        n_errors++;
        $display("Error response dropped or changed before it was accepted in %s", cur_test);
      end
      mst_hold    = mst_req_valid_o && !mst_req_ready_i;
      err_hold    = slv_err_valid_o && !slv_err_ready_i;
      hold_addr   = mst_req_addr_o;
      hold_mst_id = mst_req_id_o;
      hold_write  = mst_req_write_o;
      hold_err_id = slv_err_id_o;

      if ((rab_miss_irq_o || rab_multi_irq_o || rab_prot_irq_o) && !slv_err_valid_o) begin
        n_errors++;
        $display("Interrupt pulse without an error response in %s", cur_test);
      end
      if (rab_miss_irq_o) irq_cnt[KIND_MISS]++;
      if (rab_multi_irq_o) irq_cnt[KIND_MULTI]++;
      if (rab_prot_irq_o) irq_cnt[KIND_PROT]++;

      if (mst_req_valid_o && mst_req_ready_i) begin
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("Master request with no cluster request outstanding in %s", cur_test);
        end else begin
          got_e = exp_q.pop_front();
          check("error path", got_e.kind != KIND_OK, 1'b0);
          check("master addr", got_e.addr, mst_req_addr_o);
          check("master id", got_e.id, mst_req_id_o);
          check("master write", got_e.write, mst_req_write_o);
          if (got_e.lat_chk) check("latency", 2, cycle - got_e.cyc);
        end
      end
      if (slv_err_valid_o && slv_err_ready_i) begin
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("Error response with no cluster request outstanding in %s", cur_test);
        end else begin
          got_e = exp_q.pop_front();
          check("error path", got_e.kind != KIND_OK, 1'b1);
          check("error id", got_e.id, slv_err_id_o);
          check("error resp", RESP_SLVERR, slv_err_resp_o);
          if (got_e.lat_chk) check("latency", 2, cycle - got_e.cyc);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d requests outstanding", cycle, exp_q.size());
      $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
      $display("Result: FAILED");
      $finish;
    end
  end

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    conf_aw_addr_i = '0;
    conf_aw_valid_i = 1'b0;
    conf_w_data_i = '0;
    conf_w_valid_i = 1'b0;
    conf_b_ready_i = 1'b1;
    conf_ar_addr_i = '0;
    conf_ar_valid_i = 1'b0;
    conf_r_ready_i = 1'b1;
    slv_req_valid_i = 1'b0;
    slv_req_addr_i = '0;
    slv_req_id_i = '0;
    slv_req_write_i = 1'b0;
    mst_req_ready_i = 1'b1;
    slv_err_ready_i = 1'b1;
    cycle = '0;
    n_checks = 0;
    n_errors = 0;
    stim_lfsr = 32'h1b52_5ac4;
    rdy_lfsr = 32'h1b52_5ac4;
    rand_ready = 1'b0;
    exp_cnt = '{default: 0};
    irq_cnt = '{default: 0};
    for (int i = 0; i < N_SLICES; i++) begin
      sh_start[i] = '0;
      sh_end[i] = '0;
      sh_off[i] = '0;
      sh_flags[i] = '0;
    end
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;

    cur_test = "register access";
    // Upper flag bits are not stored and read back as zero
    set_slice(0, 32'h1000_0000, 32'h1000_ffff, 32'h8000_0000, 32'h0000_0107);
    set_slice(1, 32'h2000_0000, 32'h2000_3fff, 32'h9000_0000, 32'h0000_0007);
    set_slice(2, 32'h3000_0000, 32'h3000_0fff, 32'ha000_0000, 32'h0000_0003);
    set_slice(3, 32'h4000_0000, 32'h4000_ffff, 32'hb000_0000, 32'h0000_0000);
    for (int i = 0; i < N_SLICES; i++) begin
      cfg_read(i * SLICE_STRIDE + OFS_START, sh_start[i], RESP_OKAY, "start");
      cfg_read(i * SLICE_STRIDE + OFS_END, sh_end[i], RESP_OKAY, "end");
      cfg_read(i * SLICE_STRIDE + OFS_OFFSET, sh_off[i], RESP_OKAY, "offset");
      cfg_read(i * SLICE_STRIDE + OFS_FLAGS, {29'd0, sh_flags[i][2:0]}, RESP_OKAY, "flags");
    end

    cur_test = "translation";
    for (int n = 0; n < N_XLAT; n++) begin
      if (rand_bits(1)) send_rand(32'h2000_0000, 12);
      else send_rand(32'h1000_0000, 12);
    end
    wait_drain();
    check_irqs();

    cur_test = "misses";
    // Slice 3 is still disabled, so these all miss
    for (int n = 0; n < 3; n++) send_rand(32'h4000_0000, 12);
    wait_drain();
    check_irqs();
    check_miss_log();

    cur_test = "protection";
    send_req(32'h3000_0010, 4'h5, 1'b1);
    send_req(32'h3000_0020, 4'h6, 1'b0);
    wait_drain();
    check_irqs();

    cur_test = "overlap";
    set_slice(3, 32'h1000_8000, 32'h1001_0000, 32'hb000_0000, 32'h0000_0007);
    send_req(32'h1000_9000, 4'h7, 1'b0);
    send_req(32'h1001_0000, 4'h8, 1'b1);
    send_req(32'h1000_0100, 4'h9, 1'b0);
    wait_drain();
    check_irqs();

    cur_test = "back-pressure";
    set_ready_mode(1'b1);
    for (int n = 0; n < N_BP; n++) begin
      send_rand(mixed_base(rand_bits(3)), 12);
      if (rand_bits(1)) begin
        @(negedge clk_i);
        slv_req_valid_i = 1'b0;
      end
    end
    wait_drain();
    set_ready_mode(1'b0);
    for (int n = 0; n < N_LAT; n++) send_rand(32'h2000_0000, 12);
    wait_drain();
    check_irqs();

    cur_test = "fifo full";
    check_miss_log();
    check_irqs();
    for (int n = 0; n < MISS_DEPTH + 2; n++) send_rand(32'h6000_0000, 16);
    wait_drain();
    check_irqs();
    check_miss_log();
    check_irqs();

    cur_test = "decode errors";
    // 0x40 would alias slice 0 if the index were only truncated
    cfg_write(32'h0000_0040, 32'hdead_beef, RESP_DECERR, "unmapped write");
    cfg_read(32'h0000_0040, '0, RESP_DECERR, "unmapped read");
    cfg_read(32'h0000_0002, '0, RESP_DECERR, "unaligned read");
    cfg_read(32'h0000_0200, '0, RESP_DECERR, "far read");
    cfg_read(OFS_START, sh_start[0], RESP_OKAY, "slice 0 start kept");

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
